// File: src.f
+incdir+logic
logic/tmr_pkg.sv
logic/instr_aligner.sv
logic/lane_voter.sv
logic/lane_health_monitor.sv
logic/tmr_aligner_top.sv
testbench/tb_tmr_aligner.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_tmr_aligner
RTL_TOP    := tmr_aligner_top
FILELIST   := src.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Pass only if the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_tmr_aligner.sv
/*
 * Directed tests for the redundant aligner against a halfword stream model.
 * Inputs change 1 ns after the rising edge and outputs are sampled on the falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tmr_settings.svh"

module tb_tmr_aligner import tmr_pkg::*; ();

        // Faulty cycles in a row that push a clean counter to the threshold
        localparam int FAULTS_TO_BREAK =
                (`HEALTH_THRESHOLD + `HEALTH_INCREMENT - 1) / `HEALTH_INCREMENT;
        localparam int STREAM_TIMEOUT = 1000;

        logic      clk;
        logic      reset_i;
        logic      fetch_valid_i;
        word_t     fetch_rdata_i;
        logic      branch_i;
        word_t     branch_addr_i;
        logic      instr_ready_i;
        lane_vec_t inject_fault_i;
        lane_vec_t set_broken_i;
        logic      aligner_ready_o;
        logic      instr_valid_o;
        word_t     instr_aligned_o;
        word_t     pc_o;
        lane_vec_t is_broken_o;
        logic      err_detected_o;
        logic      err_corrected_o;

        int          checks;
        int          errors;
        int          timeouts;
        logic [31:0] rng_state;

        word_t fetch_words[$];
        word_t exp_instr[$];
        word_t exp_pc[$];

        always #50 clk = ~clk;

        tmr_aligner_top uut (
                .clk             (clk),
                .reset_i         (reset_i),
                .fetch_valid_i   (fetch_valid_i),
                .fetch_rdata_i   (fetch_rdata_i),
                .aligner_ready_o (aligner_ready_o),
                .branch_i        (branch_i),
                .branch_addr_i   (branch_addr_i),
                .instr_ready_i   (instr_ready_i),
                .instr_valid_o   (instr_valid_o),
                .instr_aligned_o (instr_aligned_o),
                .pc_o            (pc_o),
                .inject_fault_i  (inject_fault_i),
                .set_broken_i    (set_broken_i),
                .is_broken_o     (is_broken_o),
                .err_detected_o  (err_detected_o),
                .err_corrected_o (err_corrected_o)
        );

        ////////////////////////////////////////////////////////////
        // Helpers
        ////////////////////////////////////////////////////////////

        // 32-bit xorshift
        function automatic logic [31:0] next_random();
                rng_state = rng_state ^ (rng_state << 13);
                rng_state = rng_state ^ (rng_state >> 17);
                rng_state = rng_state ^ (rng_state << 5);
                return rng_state;
        endfunction

        task automatic expect_equal(input string what, input logic [31:0] got,
                                    input logic [31:0] exp);
                checks++;
                assert (got === exp) else begin
                        errors++;
                        $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
                end
        endtask

        task automatic drive_idle();
                fetch_valid_i  = 1'b0;
                fetch_rdata_i  = '0;
                branch_i       = 1'b0;
                branch_addr_i  = '0;
                instr_ready_i  = 1'b1;
                inject_fault_i = '0;
                set_broken_i   = '0;
        endtask

        task automatic reset_dut();
                @(posedge clk);
                #1;
                drive_idle();
                reset_i = 1'b1;
                repeat (3) @(posedge clk);
                #1 reset_i = 1'b0;
        endtask

        // Random instructions packed into fetch words, little-endian halfwords
        task automatic build_stream(input int n_instr, input bit full_only, input bit skip_low);
                logic [15:0] halves[$];
                logic [31:0] r;
                logic [15:0] h;
                fetch_words.delete();
                if (skip_low) begin
                        r = next_random();
                        halves.push_back(r[15:0]);
                end
                for (int i = 0; i < n_instr; i++) begin
                        r = next_random();
                        if (full_only || r[31]) begin
                                halves.push_back({r[15:2], 2'b11});
                                halves.push_back(r[30:15]);
                        end else begin
                                h = r[15:0];
                                if (h[1:0] == 2'b11) begin
                                        h[1:0] = 2'b01;
                                end
                                halves.push_back(h);
                        end
                end
                // Compressed nop as padding so the last word is complete
                if (halves.size() % 2 != 0) begin
                        halves.push_back(16'h0001);
                end
                for (int i = 0; i < halves.size(); i += 2) begin
                        fetch_words.push_back({halves[i+1], halves[i]});
                end
        endtask

        // Reference model of the instruction stream seen at the decode side
        task automatic model_stream(input word_t start_pc, input bit skip_low);
                logic [15:0] halves[$];
                logic [15:0] lo;
                logic [15:0] hi;
                word_t       pc;
                exp_instr.delete();
                exp_pc.delete();
                foreach (fetch_words[i]) begin
                        halves.push_back(fetch_words[i][15:0]);
                        halves.push_back(fetch_words[i][31:16]);
                end
                if (skip_low) begin
                        void'(halves.pop_front());
                end
                pc = start_pc;
                while (halves.size() > 0) begin
                        lo = halves.pop_front();
                        exp_pc.push_back(pc);
                        if (lo[1:0] == 2'b11) begin
                                hi = halves.pop_front();
                                exp_instr.push_back({hi, lo});
                                pc = pc + 4;
                        end else begin
                                exp_instr.push_back({16'h0000, lo});
                                pc = pc + 2;
                        end
                end
        endtask

        task automatic branch_to(input word_t addr);
                @(posedge clk);
                #1;
                drive_idle();
                branch_i      = 1'b1;
                branch_addr_i = addr;
                @(negedge clk);
                expect_equal("instr_valid_o during branch", instr_valid_o, 0);
                expect_equal("aligner_ready_o during branch", aligner_ready_o, 0);
        endtask

        task automatic start_stream(input word_t addr, input int n_instr, input bit full_only);
                build_stream(n_instr, full_only, addr[1]);
                model_stream(addr, addr[1]);
                branch_to(addr);
        endtask

        // Feeds fetch_words and checks every decode handshake against the model
        task automatic run_stream(input bit stall, input lane_vec_t fault_lanes,
                                  input int fault_cycle, input bit exp_corrected);
                int          wi;
                int          cycle;
                logic [31:0] r;
                wi    = 0;
                cycle = 0;
                while (exp_instr.size() > 0) begin
                        if (cycle > STREAM_TIMEOUT) begin
                                timeouts++;
                                $display("Timeout at %0t ns: stream stalled with %0d left",
                                         $time, exp_instr.size());
                                break;
                        end
                        @(posedge clk);
                        #1;
                        r              = next_random();
                        branch_i       = 1'b0;
                        fetch_valid_i  = (wi < fetch_words.size());
                        fetch_rdata_i  = fetch_valid_i ? fetch_words[wi] : '0;
                        instr_ready_i  = !stall || (r[1:0] != 2'b00);
                        inject_fault_i = (cycle == fault_cycle) ? fault_lanes : '0;
                        @(negedge clk);
                        if (cycle == fault_cycle) begin
                                expect_equal("handshake in fault cycle",
                                             instr_valid_o && instr_ready_i, 1);
                                expect_equal("err_detected_o on fault", err_detected_o, 1);
                                expect_equal("err_corrected_o on fault", err_corrected_o,
                                             exp_corrected);
                        end else begin
                                expect_equal("err_detected_o", err_detected_o, 0);
                                expect_equal("err_corrected_o", err_corrected_o, 0);
                        end
                        if (instr_valid_o && instr_ready_i) begin
                                expect_equal("instr_aligned_o", instr_aligned_o, exp_instr[0]);
                                expect_equal("pc_o", pc_o, exp_pc[0]);
                                void'(exp_instr.pop_front());
                                void'(exp_pc.pop_front());
                        end
                        if (fetch_valid_i && aligner_ready_o) begin
                                wi++;
                        end
                        cycle++;
                end
                expect_equal("fetch words consumed", wi, fetch_words.size());
                // Nothing may follow the last instruction
                @(posedge clk);
                #1;
                drive_idle();
                @(negedge clk);
                expect_equal("instr_valid_o after stream", instr_valid_o, 0);
        endtask

        ////////////////////////////////////////////////////////////
        // Tests
        ////////////////////////////////////////////////////////////

        task automatic full_word_stream();
                start_stream(32'h0000_0100, 16, 1'b1);
                run_stream(1'b0, '0, -1, 1'b0);
        endtask

        task automatic mixed_with_backpressure();
                start_stream(32'h0000_1000, 60, 1'b0);
                run_stream(1'b1, '0, -1, 1'b0);
        endtask

        task automatic halfword_branch();
                start_stream(32'h0000_2002, 24, 1'b0);
                run_stream(1'b1, '0, -1, 1'b0);
        endtask

        task automatic single_fault_corrected();
                start_stream(32'h0000_3000, 16, 1'b0);
                // All lanes healthy, so the fault is outvoted
                run_stream(1'b0, 3'b100, 2, 1'b1);
                expect_equal("is_broken_o after one fault", is_broken_o, 0);
        endtask

        task automatic lane_breaks_after_faults();
                reset_dut();
                for (int c = 0; c < FAULTS_TO_BREAK; c++) begin
                        @(posedge clk);
                        #1 inject_fault_i = 3'b010;
                        @(negedge clk);
                        expect_equal("err_detected_o on lane 1", err_detected_o, 1);
                        expect_equal("err_corrected_o on lane 1", err_corrected_o, 1);
                        expect_equal("is_broken_o while faulting", is_broken_o, 0);
                end
                @(posedge clk);
                #1 inject_fault_i = '0;
                @(negedge clk);
                expect_equal("is_broken_o after faults", is_broken_o, 3'b010);
                // Lane 0 must now carry the output alone against lane 2
                start_stream(32'h0000_4000, 16, 1'b0);
                run_stream(1'b0, 3'b100, 2, 1'b0);
                expect_equal("is_broken_o after lane 2 fault", is_broken_o, 3'b010);
        endtask

        task automatic forced_broken_sticky();
                reset_dut();
                @(posedge clk);
                #1 set_broken_i = 3'b001;
                @(negedge clk);
                expect_equal("is_broken_o with set_broken_i", is_broken_o, 0);
                @(posedge clk);
                #1 set_broken_i = '0;
                @(negedge clk);
                expect_equal("is_broken_o after set_broken_i", is_broken_o, 3'b001);
                repeat (8) begin
                        @(negedge clk);
                        expect_equal("is_broken_o held", is_broken_o, 3'b001);
                end
                reset_dut();
                @(negedge clk);
                expect_equal("is_broken_o after reset", is_broken_o, 0);
                expect_equal("instr_valid_o after reset", instr_valid_o, 0);
                expect_equal("aligner_ready_o after reset", aligner_ready_o, instr_ready_i);
                @(posedge clk);
                #1 instr_ready_i = 1'b0;
                @(negedge clk);
                expect_equal("aligner_ready_o with instr_ready_i low", aligner_ready_o, 0);
        endtask

        initial begin
                clk       = 1'b0;
                rng_state = 32'd19;
                checks    = 0;
                errors    = 0;
                timeouts  = 0;
                reset_i   = 1'b1;
                drive_idle();
                repeat (3) @(posedge clk);
                #1 reset_i = 1'b0;

                full_word_stream();
                mixed_with_backpressure();
                halfword_branch();
                single_fault_corrected();
                lane_breaks_after_faults();
                forced_broken_sticky();

                $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
                if (errors == 0 && timeouts == 0) begin
                        $display("Test OK");
                end else begin
                        $display("Test FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: logic/tmr_aligner_top.sv
/*
 * Triple-redundant aligner with one shared input set and voted outputs.
 * inject_fault_i inverts a copy's instruction word for test only.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tmr_settings.svh"

module tmr_aligner_top import tmr_pkg::*; (
        input  logic      clk,
        input  logic      reset_i,

        input  logic      fetch_valid_i,
        input  word_t     fetch_rdata_i,
        output logic      aligner_ready_o,

        input  logic      branch_i,
        input  word_t     branch_addr_i,

        input  logic      instr_ready_i,
        output logic      instr_valid_o,
        output word_t     instr_aligned_o,
        output word_t     pc_o,

        // Fault handling
        input  lane_vec_t inject_fault_i,
        input  lane_vec_t set_broken_i,
        output lane_vec_t is_broken_o,
        output logic      err_detected_o,
        output logic      err_corrected_o
);

        logic [`TMR_LANES-1:0][0:0] ready_lanes;
        logic [`TMR_LANES-1:0][0:0] valid_lanes;
        word_t [`TMR_LANES-1:0]     raw_instr;
        word_t [`TMR_LANES-1:0]     instr_lanes;
        word_t [`TMR_LANES-1:0]     pc_lanes;

        lane_vec_t  ready_err;
        lane_vec_t  valid_err;
        lane_vec_t  instr_err;
        lane_vec_t  pc_err;
        lane_vec_t  lane_err;
        logic [3:0] detected;
        logic [3:0] corrected;

        ////////////////////////////////////////////////////////////
        // Redundant copies
        ////////////////////////////////////////////////////////////

        for (genvar l = 0; l < `TMR_LANES; l++) begin : g_lane
                instr_aligner u_aligner (
                        .clk             (clk),
                        .reset_i         (reset_i),
                        .fetch_valid_i   (fetch_valid_i),
                        .fetch_rdata_i   (fetch_rdata_i),
                        .aligner_ready_o (ready_lanes[l]),
                        .branch_i        (branch_i),
                        .branch_addr_i   (branch_addr_i),
                        .instr_ready_i   (instr_ready_i),
                        .instr_valid_o   (valid_lanes[l]),
                        .instr_aligned_o (raw_instr[l]),
                        .pc_o            (pc_lanes[l])
                );

                // Flip the whole word while the lane's fault bit is set
                assign instr_lanes[l] = raw_instr[l] ^ {`TMR_XLEN{inject_fault_i[l]}};
        end

        ////////////////////////////////////////////////////////////
        // Output voters
        ////////////////////////////////////////////////////////////

        lane_voter #(.WIDTH(1)) u_vote_ready (
                .lanes_i         (ready_lanes),
                .broken_i        (is_broken_o),
                .voted_o         (aligner_ready_o),
                .lane_err_o      (ready_err),
                .err_detected_o  (detected[0]),
                .err_corrected_o (corrected[0])
        );

        lane_voter #(.WIDTH(1)) u_vote_valid (
                .lanes_i         (valid_lanes),
                .broken_i        (is_broken_o),
                .voted_o         (instr_valid_o),
                .lane_err_o      (valid_err),
                .err_detected_o  (detected[1]),
                .err_corrected_o (corrected[1])
        );

        lane_voter #(.WIDTH(`TMR_XLEN)) u_vote_instr (
                .lanes_i         (instr_lanes),
                .broken_i        (is_broken_o),
                .voted_o         (instr_aligned_o),
                .lane_err_o      (instr_err),
                .err_detected_o  (detected[2]),
                .err_corrected_o (corrected[2])
        );

        lane_voter #(.WIDTH(`TMR_XLEN)) u_vote_pc (
                .lanes_i         (pc_lanes),
                .broken_i        (is_broken_o),
                .voted_o         (pc_o),
                .lane_err_o      (pc_err),
                .err_detected_o  (detected[3]),
                .err_corrected_o (corrected[3])
        );

        assign err_detected_o  = |detected;
        assign err_corrected_o = |corrected;

        // A lane is at fault if any of its outputs lost the vote
        assign lane_err = ready_err | valid_err | instr_err | pc_err;

        lane_health_monitor u_health (
                .clk          (clk),
                .reset_i      (reset_i),
                .lane_err_i   (lane_err),
                .set_broken_i (set_broken_i),
                .is_broken_o  (is_broken_o)
        );

endmodule

`default_nettype wire

// File: logic/lane_health_monitor.sv
/*
 * Saturating error counter per lane with sticky broken flags.
 * Flags clear only on reset.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tmr_settings.svh"

module lane_health_monitor import tmr_pkg::*; (
        input  logic      clk,
        input  logic      reset_i,
        input  lane_vec_t lane_err_i,
        input  lane_vec_t set_broken_i,
        output lane_vec_t is_broken_o
);

        typedef logic [`HEALTH_COUNT_BITS-1:0] count_t;

        localparam count_t COUNT_MAX = '1;
        localparam count_t COUNT_INC = `HEALTH_INCREMENT;
        localparam count_t COUNT_DEC = `HEALTH_DECREMENT;
        localparam count_t COUNT_THR = `HEALTH_THRESHOLD;

        count_t    count_q [`TMR_LANES];
        count_t    count_d [`TMR_LANES];
        lane_vec_t broken_q;
        lane_vec_t broken_d;

        assign is_broken_o = broken_q;

        always_comb begin
                for (int l = 0; l < `TMR_LANES; l++) begin
                        if (lane_err_i[l]) begin
                                // Clamp at the top of the counter
                                count_d[l] = (count_q[l] > COUNT_MAX - COUNT_INC) ?
                                             COUNT_MAX : count_q[l] + COUNT_INC;
                        end else begin
                                count_d[l] = (count_q[l] < COUNT_DEC) ?
                                             '0 : count_q[l] - COUNT_DEC;
                        end
                        broken_d[l] = broken_q[l] | set_broken_i[l] |
                                      (count_d[l] >= COUNT_THR);
                end
        end

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        broken_q <= '0;
                        for (int l = 0; l < `TMR_LANES; l++) begin
                                count_q[l] <= '0;
                        end
                end else begin
                        broken_q <= broken_d;
                        for (int l = 0; l < `TMR_LANES; l++) begin
                                count_q[l] <= count_d[l];
                        end
                end
        end

endmodule

`default_nettype wire

// File: logic/lane_voter.sv
/*
 * Bitwise voter over the redundant copies with broken-lane masking.
 * Written for three lanes. Purely combinational.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tmr_settings.svh"

module lane_voter import tmr_pkg::*; #(
        parameter int unsigned WIDTH = 1
) (
        input  logic [`TMR_LANES-1:0][WIDTH-1:0] lanes_i,
        input  lane_vec_t                        broken_i,
        output logic [WIDTH-1:0]                 voted_o,
        output lane_vec_t                        lane_err_o,
        output logic                             err_detected_o,
        output logic                             err_corrected_o
);

        logic [WIDTH-1:0] majority;
        logic [WIDTH-1:0] first_healthy;
        lane_vec_t        differs;
        lane_vec_t        healthy_diff;
        int unsigned      broken_count;

        assign majority = (lanes_i[0] & lanes_i[1])
                        | (lanes_i[0] & lanes_i[2])
                        | (lanes_i[1] & lanes_i[2]);

        // Lowest healthy lane wins, lane 0 if none is healthy
        always_comb begin
                first_healthy = lanes_i[0];
                for (int l = `TMR_LANES - 1; l >= 0; l--) begin
                        if (!broken_i[l]) begin
                                first_healthy = lanes_i[l];
                        end
                end
        end

        assign broken_count = $countones(broken_i);
        assign voted_o      = (broken_count == 0) ? majority : first_healthy;

        always_comb begin
                for (int l = 0; l < `TMR_LANES; l++) begin
                        differs[l] = |(lanes_i[l] ^ voted_o);
                end
        end

        assign healthy_diff = differs & ~broken_i;

        always_comb begin
                lane_err_o      = '0;
                err_detected_o  = 1'b0;
                err_corrected_o = 1'b0;
                case (broken_count)
                        0: begin
                                lane_err_o      = differs;
                                err_detected_o  = |differs;
                                err_corrected_o = |differs;
                        end
                        // One spare left, mismatches are seen but not outvoted
                        1: begin
                                lane_err_o     = healthy_diff;
                                err_detected_o = |healthy_diff;
                        end
                        default: ;
                endcase
        end

endmodule

`default_nettype wire

// File: logic/instr_aligner.sv
/*
 * Splits 32-bit fetch words into 16/32-bit instructions with their PC.
 * branch_addr_i must be even. Outputs are combinational with zero latency.
 */
`timescale 1ns/1ps
`default_nettype none

module instr_aligner import tmr_pkg::*; (
        input  logic  clk,
        input  logic  reset_i,

        // Fetch side
        input  logic  fetch_valid_i,
        input  word_t fetch_rdata_i,
        output logic  aligner_ready_o,

        // Branch redirect
        input  logic  branch_i,
        input  word_t branch_addr_i,

        // Decode side
        input  logic  instr_ready_i,
        output logic  instr_valid_o,
        output word_t instr_aligned_o,
        output word_t pc_o
);

        // State a held upper halfword leads to
        function automatic aligner_state_e held_state(input logic [15:0] half);
                if (half[1:0] == 2'b11) begin
                        return MISALIGNED_32;
                end
                return MISALIGNED_16;
        endfunction

        aligner_state_e state_q;
        aligner_state_e state_d;
        word_t          pc_q;
        word_t          pc_d;
        word_t          pc_inc;
        logic [15:0]    held_q;
        logic [15:0]    held_d;
        logic           adv;
        logic           hold_upper;

        assign pc_o = pc_q;

        ////////////////////////////////////////////////////////////
        // Output decode and next state
        ////////////////////////////////////////////////////////////

        always_comb begin
                instr_valid_o   = 1'b0;
                aligner_ready_o = 1'b0;
                instr_aligned_o = fetch_rdata_i;
                adv             = 1'b0;
                hold_upper      = 1'b0;
                pc_inc          = '0;

                case (state_q)
                        ALIGNED: begin
                                instr_valid_o   = fetch_valid_i;
                                aligner_ready_o = instr_ready_i;
                                adv             = fetch_valid_i & instr_ready_i;
                                if (fetch_rdata_i[1:0] == 2'b11) begin
                                        pc_inc = word_t'(4);
                                end else begin
                                        // Compressed low half with the upper one held
                                        instr_aligned_o = word_t'(fetch_rdata_i[15:0]);
                                        pc_inc          = word_t'(2);
                                        hold_upper      = 1'b1;
                                end
                        end
                        MISALIGNED_32: begin
                                // Full instruction straddling the held half and this word
                                instr_valid_o   = fetch_valid_i;
                                aligner_ready_o = instr_ready_i;
                                adv             = fetch_valid_i & instr_ready_i;
                                instr_aligned_o = {fetch_rdata_i[15:0], held_q};
                                pc_inc          = word_t'(4);
                                hold_upper      = 1'b1;
                        end
                        MISALIGNED_16: begin
                                // Held half is a whole instruction and the fetch word waits
                                instr_valid_o   = 1'b1;
                                instr_aligned_o = word_t'(held_q);
                                adv             = instr_ready_i;
                                pc_inc          = word_t'(2);
                        end
                        default: begin
                                // Skip the low half of the first word after the branch
                                aligner_ready_o = 1'b1;
                                adv             = fetch_valid_i;
                                hold_upper      = 1'b1;
                        end
                endcase

                state_d = state_q;
                pc_d    = pc_q;
                held_d  = held_q;

                if (branch_i) begin
                        instr_valid_o   = 1'b0;
                        aligner_ready_o = 1'b0;
                        pc_d            = branch_addr_i;
                        state_d         = branch_addr_i[1] ? BRANCH_MISALIGNED : ALIGNED;
                end else if (adv) begin
                        pc_d = pc_q + pc_inc;
                        if (hold_upper) begin
                                held_d  = fetch_rdata_i[31:16];
                                state_d = held_state(fetch_rdata_i[31:16]);
                        end else begin
                                state_d = ALIGNED;
                        end
                end
        end

        ////////////////////////////////////////////////////////////
        // Registers
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        state_q <= ALIGNED;
                        pc_q    <= '0;
                end else begin
                        state_q <= state_d;
                        pc_q    <= pc_d;
                end
        end

        // Held upper halfword
        always_ff @(posedge clk) begin
                held_q <= held_d;
        end

endmodule

`default_nettype wire

// File: logic/tmr_pkg.sv
/*
 * Shared types for the redundant aligner.
 * Widths come from the settings header.
 */
`default_nettype none

`include "tmr_settings.svh"

package tmr_pkg;

        // One instruction or address word
        typedef logic [`TMR_XLEN-1:0] word_t;

        // One bit per redundant copy
        typedef logic [`TMR_LANES-1:0] lane_vec_t;

        // Aligner FSM states
        typedef enum logic [1:0] {
                ALIGNED,            // nothing held
                MISALIGNED_32,      // held half starts a full instruction
                MISALIGNED_16,      // held half is a whole compressed instruction
                BRANCH_MISALIGNED   // branch landed on the upper half of a word
        } aligner_state_e;

endpackage

`default_nettype wire

// File: logic/tmr_settings.svh
/*
 * Build constants for the redundant aligner. TMR_LANES must stay 3, the voters
 * use a three-input majority. Health constants must fit the counter width.
 */
`ifndef TMR_SETTINGS_SVH
`define TMR_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Redundancy and datapath
////////////////////////////////////////////////////////////

// Number of redundant aligner copies
`define TMR_LANES 3

// Instruction and address width
`define TMR_XLEN 32

////////////////////////////////////////////////////////////
// Lane health counters
////////////////////////////////////////////////////////////

// Width of each lane's error counter
`define HEALTH_COUNT_BITS 5

// Added per cycle with an error, removed per clean cycle
`define HEALTH_INCREMENT 4
`define HEALTH_DECREMENT 1

// Count at which a lane is declared broken
`define HEALTH_THRESHOLD 12

`endif
